// File: dv/ahb_testdata.hex
// Columns: test op addr wdata exp_rdata exp_resp (resp 1 is ERROR)
// Ops: 0 idle, 1 write, 2 read, 3 write with HSEL low, 4 read with HSEL low
1 1 00000010 a5a50001 00000000 0
1 2 00000010 00000000 a5a50001 0
1 1 20000024 a5a50002 00000000 0
1 2 20000024 00000000 a5a50002 0
1 1 40000038 a5a50003 00000000 0
1 2 40000038 00000000 a5a50003 0
2 2 80000000 00000000 00000000 1
2 1 80000010 deadbeef 00000000 1
2 2 60000000 00000000 00000000 1
2 2 00000010 00000000 a5a50001 0
3 1 00000100 11110000 00000000 0
3 1 20000100 22220000 00000000 0
3 1 40000100 33330000 00000000 0
3 2 00000100 00000000 11110000 0
3 2 20000100 00000000 22220000 0
3 2 40000100 00000000 33330000 0
4 1 00000200 cafe0001 00000000 0
4 2 20000100 00000000 22220000 0
4 2 00000200 00000000 cafe0001 0
4 1 5ffffffc 0badf00d 00000000 0
4 2 5ffffffc 00000000 0badf00d 0
5 0 00000000 00000000 00000000 0
5 3 00000010 99999999 00000000 0
5 4 80000000 00000000 00000000 0
5 2 00000010 00000000 a5a50001 0
5 1 80000040 12345678 00000000 1
5 2 00000010 00000000 a5a50001 0

// File: sources.f
logic/ahb_pkg.sv
logic/bus_map_pkg.sv
logic/ahb_default_slave.sv
logic/ahb_sram_slave.sv
logic/ahb_bus_decoder.sv
logic/ahb_bus_system.sv
dv/tb_ahb_bus_system.sv

// File: Makefile
# Verilator build and run for the AHB-Lite bus slice

VERILATOR   ?= verilator
TOP         ?= tb_ahb_bus_system
WAIT_STATES ?= 1
SEED        ?= 24161
LOG         ?= sim.log
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GWAIT_STATES=$(WAIT_STATES) \
		-GSEED=$(SEED) --Mdir $(OBJ_DIR) -f sources.f

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_ahb_bus_system.sv
// Self-checking testbench for the AHB-Lite bus slice replaying directed vectors and random traffic
`timescale 1ns/1ns

module tb_ahb_bus_system;
  import ahb_pkg::*;
  import bus_map_pkg::*;

  parameter int SRAM_WORDS  = 256;
  parameter int WAIT_STATES = 1;
  parameter int SEED        = 32'h5e61;

  localparam int FIELDS     = 6;   // Words per entry in the data file
  localparam int MAX_ENTRY  = 64;
  localparam int RAND_COUNT = 64;  // Random transfers after the directed list

  logic                  hclk;
  logic                  hresetn;
  logic                  hsel;
  logic [AHB_ADDR_W-1:0] haddr;
  htrans_e               htrans;
  logic                  hwrite;
  logic [AHB_DATA_W-1:0] hwdata;
  logic                  hreadyout;
  hresp_e                hresp;
  logic [AHB_DATA_W-1:0] hrdata;

  logic [31:0] tv [FIELDS*MAX_ENTRY];  // Flat image of the data file
  logic [31:0] shadow [3*SRAM_WORDS];  // Expected memory with one slice per region
  bit          written [3*SRAM_WORDS];
  int          n_entries;
  int          wd_limit;               // Watchdog budget in ns
  int          seed;
  int          err_cnt;
  int          check_cnt;
  int          tests_run;
  int          tests_failed;
  int          test_err_base;

  // Data phase still owed by the DUT
  bit          pend_valid;
  logic [31:0] pend_wdata;
  logic [31:0] pend_rdata;
  logic        pend_err;
  int          pend_waits;

  ahb_bus_system #(.SRAM_WORDS(SRAM_WORDS), .WAIT_STATES(WAIT_STATES)) u_dut (
    .HCLK      (hclk),
    .HRESETn   (hresetn),
    .HSEL      (hsel),
    .HADDR     (haddr),
    .HTRANS    (htrans),
    .HWRITE    (hwrite),
    .HWDATA    (hwdata),
    .HREADYOUT (hreadyout),
    .HRESP     (hresp),
    .HRDATA    (hrdata)
  );

  always #2 hclk = ~hclk;  // 4 ns period

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    check_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("** Error: %s = 0x%08h, expected 0x%08h at %0t ns", name, act, exp, $time);
    end
  endtask

  // Region index from the memory map with 3 for unmapped space
  function automatic int region_of(input logic [31:0] addr);
    logic [21:0] da;
    da = addr[31:DECODE_LSB];
    if (da <= REGION0_LAST)
      return 0;
    if (da <= REGION1_LAST)
      return 1;
    if (da <= REGION2_LAST)
      return 2;
    return 3;
  endfunction

  function automatic int shadow_idx(input logic [31:0] addr);
    return region_of(addr) * SRAM_WORDS + int'((addr >> 2) % SRAM_WORDS);  // Wraps at depth
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "write/read per region";
      2:       return "unmapped ERROR";
      3:       return "same offset, three regions";
      4:       return "back-to-back pipelining";
      5:       return "IDLE, HSEL low, after ERROR";
      default: return "random vs shadow";
    endcase
  endfunction

  // New address phase followed by a check of the older data phase once it completes
  task automatic issue(input int op, input logic [31:0] addr, input logic [31:0] wdata,
                       input logic [31:0] exp_rdata, input logic exp_err, input logic seq);
    int waits;
    @(negedge hclk);
    hsel   = !(op == 3 || op == 4);        // Ops 3 and 4 run unselected
    htrans = (op == 0) ? IDLE : (seq ? SEQ : NONSEQ);
    hwrite = (op == 1 || op == 3);
    haddr  = addr;
    hwdata = pend_wdata;                   // Belongs to the older transfer
    waits  = 0;
    #1;
    while (!hreadyout)
    begin
      if (pend_err && waits == 0)
        check_val("HRESP", 32'(hresp), 32'(ERROR));  // First ERROR cycle
      waits++;
      @(negedge hclk);
      #1;
    end
    if (pend_valid)
    begin
      check_val("HRESP", 32'(hresp), 32'(pend_err));
      check_val("HRDATA", hrdata, pend_rdata);
      check_val("wait_cycles", waits, pend_waits);
    end
    pend_valid = 1'b1;
    pend_wdata = wdata;
    pend_rdata = exp_rdata;
    pend_err   = exp_err;
    if (exp_err)
      pend_waits = 1;                      // ERROR is always two cycles
    else if (op == 1 || op == 2)
      pend_waits = WAIT_STATES;
    else
      pend_waits = 0;
    if (op == 1 && region_of(addr) < 3)
    begin
      shadow[shadow_idx(addr)]  = wdata;
      written[shadow_idx(addr)] = 1'b1;
    end
  endtask

  task automatic finish_test(input int id);
    bit ok;
    ok = (err_cnt == test_err_base);
    tests_run++;
    if (!ok)
      tests_failed++;
    $display("test %0d %s %s", id, test_name(id), ok ? "ok" : "FAILED");
    test_err_base = err_cnt;
  endtask

  // ------------------------------
  // Watchdog
  // ------------------------------
  initial
  begin
    #1;
    #(wd_limit);
    $display("Timeout after %0d ns, a data phase never completed", wd_limit);
    $display("RESULT: FAIL");
    $finish;
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    int          e;
    int          cur;
    int          region;
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] wdata;
    hclk          = 1'b0;
    hresetn       = 1'b0;
    hsel          = 1'b0;
    haddr         = '0;
    htrans        = IDLE;
    hwrite        = 1'b0;
    hwdata        = '0;
    seed          = SEED;
    err_cnt       = 0;
    check_cnt     = 0;
    tests_run     = 0;
    tests_failed  = 0;
    test_err_base = 0;
    pend_valid    = 1'b0;
    pend_wdata    = '0;
    pend_rdata    = '0;
    pend_err      = 1'b0;
    pend_waits    = 0;
    foreach (tv[i])
      tv[i] = '1;                          // All ones marks the end of the list
    $readmemh("dv/ahb_testdata.hex", tv);
    n_entries = 0;
    while (n_entries < MAX_ENTRY && tv[n_entries*FIELDS] != 32'hffff_ffff)
      n_entries++;
    wd_limit = (n_entries + RAND_COUNT) * (WAIT_STATES + 3) * 4 * 2;
    if (n_entries == 0)
    begin
      $display("No entries could be read from dv/ahb_testdata.hex");
      err_cnt++;
    end

    repeat (4) @(posedge hclk);
    @(negedge hclk);
    hresetn = 1'b1;
    #1;
    check_val("HREADYOUT", 32'(hreadyout), 32'h1);  // Reset state of the bus
    check_val("HRESP", 32'(hresp), 32'(OKAY));
    check_val("HRDATA", hrdata, '0);

    // Directed list with one test per id in the first column
    cur = int'(tv[0]);
    for (e = 0; e < n_entries; e++)
    begin
      if (int'(tv[e*FIELDS]) != cur)
      begin
        issue(0, '0, '0, '0, 1'b0, 1'b0);  // Drain the pipeline
        finish_test(cur);
        cur = int'(tv[e*FIELDS]);
      end
      issue(int'(tv[e*FIELDS+1]), tv[e*FIELDS+2], tv[e*FIELDS+3], tv[e*FIELDS+4],
            tv[e*FIELDS+5][0], 1'b0);
    end
    if (n_entries > 0)
    begin
      issue(0, '0, '0, '0, 1'b0, 1'b0);
      finish_test(cur);
    end

    // Random traffic inside the three regions
    for (e = 0; e < RAND_COUNT; e++)
    begin
      r      = $random(seed);
      region = int'(r[31:8] % 3);
      addr   = (32'(region) << 29) | ($random(seed) & 32'h1fff_fffc);
      if (r[0] || !written[shadow_idx(addr)])
      begin
        wdata = $random(seed);
        issue(1, addr, wdata, '0, 1'b0, r[1]);
      end
      else
        issue(2, addr, '0, shadow[shadow_idx(addr)], 1'b0, r[1]);  // SEQ when r[1] set
    end
    issue(0, '0, '0, '0, 1'b0, 1'b0);
    finish_test(6);

    $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             tests_run, tests_failed, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: logic/ahb_bus_system.sv
// Single-master AHB-Lite slice with address decoder, default slave and three SRAM regions
`timescale 1ns/1ns

module ahb_bus_system #(
  parameter int SRAM_WORDS  = 256,  // Words per region
  parameter int WAIT_STATES = 1     // Wait states per SRAM access
) (
  input  logic                           HCLK,
  input  logic                           HRESETn,
  input  logic                           HSEL,
  input  logic [ahb_pkg::AHB_ADDR_W-1:0] HADDR,
  input  ahb_pkg::htrans_e               HTRANS,
  input  logic                           HWRITE,
  input  logic [ahb_pkg::AHB_DATA_W-1:0] HWDATA,
  output logic                           HREADYOUT,
  output ahb_pkg::hresp_e                HRESP,
  output logic [ahb_pkg::AHB_DATA_W-1:0] HRDATA
);
  import ahb_pkg::*;
  import bus_map_pkg::*;

  logic                  sel0;
  logic                  sel1;
  logic                  sel2;
  logic                  readyout0;
  logic                  readyout1;
  logic                  readyout2;
  hresp_e                resp0;
  hresp_e                resp1;
  hresp_e                resp2;
  logic [AHB_DATA_W-1:0] rdata0;
  logic [AHB_DATA_W-1:0] rdata1;
  logic [AHB_DATA_W-1:0] rdata2;

  // One master, so bus HREADY is just the selected HREADYOUT
  wire hready = HREADYOUT;

  ahb_bus_decoder u_decoder (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .HREADY      (hready),
    .HSEL        (HSEL),
    .decode_addr (HADDR[AHB_ADDR_W-1:DECODE_LSB]),
    .HTRANS      (HTRANS),
    .readyout0   (readyout0),
    .readyout1   (readyout1),
    .readyout2   (readyout2),
    .resp0       (resp0),
    .resp1       (resp1),
    .resp2       (resp2),
    .rdata0      (rdata0),
    .rdata1      (rdata1),
    .rdata2      (rdata2),
    .sel0        (sel0),
    .sel1        (sel1),
    .sel2        (sel2),
    .HREADYOUT   (HREADYOUT),
    .HRESP       (HRESP),
    .HRDATA      (HRDATA)
  );

  // Region 0, 0x0000_0000 up
  ahb_sram_slave #(.SRAM_WORDS(SRAM_WORDS), .WAIT_STATES(WAIT_STATES)) u_sram0 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (sel0),
    .HREADY    (hready),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HWRITE    (HWRITE),
    .HWDATA    (HWDATA),
    .HREADYOUT (readyout0),
    .HRESP     (resp0),
    .HRDATA    (rdata0)
  );

  // Region 1, 0x2000_0000 up
  ahb_sram_slave #(.SRAM_WORDS(SRAM_WORDS), .WAIT_STATES(WAIT_STATES)) u_sram1 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (sel1),
    .HREADY    (hready),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HWRITE    (HWRITE),
    .HWDATA    (HWDATA),
    .HREADYOUT (readyout1),
    .HRESP     (resp1),
    .HRDATA    (rdata1)
  );

  // Region 2, 0x4000_0000 up
  ahb_sram_slave #(.SRAM_WORDS(SRAM_WORDS), .WAIT_STATES(WAIT_STATES)) u_sram2 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (sel2),
    .HREADY    (hready),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HWRITE    (HWRITE),
    .HWDATA    (HWDATA),
    .HREADYOUT (readyout2),
    .HRESP     (resp2),
    .HRDATA    (rdata2)
  );

endmodule

// File: logic/ahb_bus_decoder.sv
// Address decoder steering selects to three SRAM ports and muxing the data-phase response
`timescale 1ns/1ns

module ahb_bus_decoder (
  input  logic                                                   HCLK,
  input  logic                                                   HRESETn,
  input  logic                                                   HREADY,      // Bus ready
  input  logic                                                   HSEL,
  input  logic [ahb_pkg::AHB_ADDR_W-1:bus_map_pkg::DECODE_LSB]  decode_addr,
  input  ahb_pkg::htrans_e                                       HTRANS,
  input  logic                                                   readyout0,
  input  logic                                                   readyout1,
  input  logic                                                   readyout2,
  input  ahb_pkg::hresp_e                                        resp0,
  input  ahb_pkg::hresp_e                                        resp1,
  input  ahb_pkg::hresp_e                                        resp2,
  input  logic [ahb_pkg::AHB_DATA_W-1:0]                         rdata0,
  input  logic [ahb_pkg::AHB_DATA_W-1:0]                         rdata1,
  input  logic [ahb_pkg::AHB_DATA_W-1:0]                         rdata2,
  output logic                                                   sel0,
  output logic                                                   sel1,
  output logic                                                   sel2,
  output logic                                                   HREADYOUT,   // To master
  output ahb_pkg::hresp_e                                        HRESP,
  output logic [ahb_pkg::AHB_DATA_W-1:0]                         HRDATA
);
  import ahb_pkg::*;
  import bus_map_pkg::*;

  port_sel_e addr_port;     // Address-phase target
  port_sel_e data_port;     // Port owning the data phase
  logic      sel_dft;       // Default slave select
  logic      dft_readyout;
  hresp_e    dft_resp;

  // Unmapped accesses land here
  ahb_default_slave u_default_slave (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (sel_dft),
    .HTRANS    (HTRANS),
    .HREADY    (HREADY),
    .HREADYOUT (dft_readyout),
    .HRESP     (dft_resp)
  );

  // ------------------------------
  // Address phase
  // ------------------------------
  always_comb
  begin
    if (HTRANS == IDLE)
      addr_port = data_port;                // Idle stays on the current port
    else if (decode_addr <= REGION0_LAST)
      addr_port = PORT_MI0;
    else if (decode_addr <= REGION1_LAST)
      addr_port = PORT_MI1;
    else if (decode_addr <= REGION2_LAST)
      addr_port = PORT_MI2;
    else
      addr_port = PORT_DEFAULT;             // Anything above 0x5FFF_FFFF
  end

  // One-hot selects, gated by HSEL
  always_comb
  begin
    sel0    = 1'b0;
    sel1    = 1'b0;
    sel2    = 1'b0;
    sel_dft = 1'b0;
    if (HSEL)
    begin
      case (addr_port)
        PORT_MI0:     sel0    = 1'b1;
        PORT_MI1:     sel1    = 1'b1;
        PORT_MI2:     sel2    = 1'b1;
        PORT_DEFAULT: sel_dft = 1'b1;
        default:      sel_dft = 1'b0;
      endcase
    end
  end

  // ------------------------------
  // Data phase
  // ------------------------------

  // Moves on with the bus, not with our own HREADYOUT
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_port <= PORT_MI0;
    else if (HREADY)
      data_port <= addr_port;
  end

  // Response mux
  always_comb
  begin
    case (data_port)
      PORT_MI0:
      begin
        HREADYOUT = readyout0;
        HRESP     = resp0;
        HRDATA    = rdata0;
      end
      PORT_MI1:
      begin
        HREADYOUT = readyout1;
        HRESP     = resp1;
        HRDATA    = rdata1;
      end
      PORT_MI2:
      begin
        HREADYOUT = readyout2;
        HRESP     = resp2;
        HRDATA    = rdata2;
      end
      default:
      begin
        HREADYOUT = dft_readyout;           // Default slave has no read data
        HRESP     = dft_resp;
        HRDATA    = '0;
      end
    endcase
  end

  // Never more than one slave selected in the same cycle
  a_sel_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0({sel0, sel1, sel2, sel_dft}));

  // Data port register only ever holds one of the four codes
  a_data_port_legal: assert property (@(posedge HCLK) disable iff (!HRESETn)
    data_port inside {PORT_MI0, PORT_MI1, PORT_MI2, PORT_DEFAULT});

endmodule

// File: logic/ahb_sram_slave.sv
// Word-addressed SRAM slave with a fixed number of data-phase wait states
`timescale 1ns/1ns

module ahb_sram_slave #(
  parameter int SRAM_WORDS  = 256,  // Depth in words, power of two
  parameter int WAIT_STATES = 1     // Extra data-phase cycles
) (
  input  logic                           HCLK,
  input  logic                           HRESETn,
  input  logic                           HSEL,
  input  logic                           HREADY,
  input  logic [ahb_pkg::AHB_ADDR_W-1:0] HADDR,
  input  ahb_pkg::htrans_e               HTRANS,
  input  logic                           HWRITE,
  input  logic [ahb_pkg::AHB_DATA_W-1:0] HWDATA,
  output logic                           HREADYOUT,
  output ahb_pkg::hresp_e                HRESP,
  output logic [ahb_pkg::AHB_DATA_W-1:0] HRDATA
);
  import ahb_pkg::*;

  localparam int IDX_W = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  // ------------------------------
  // Storage and data-phase state
  // ------------------------------
  logic [AHB_DATA_W-1:0] mem [SRAM_WORDS];

  logic             dp_valid;   // Active transfer in data phase
  logic             dp_write;   // Direction of that transfer
  logic [IDX_W-1:0] dp_index;   // Word index
  logic [CNT_W-1:0] wait_cnt;   // Wait cycles still owed

  // ------------------------------
  // Address phase capture
  // ------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      dp_valid <= 1'b0;
      wait_cnt <= '0;
    end
    else if (HREADY)
    begin
      dp_valid <= HSEL && (HTRANS == NONSEQ || HTRANS == SEQ);
      wait_cnt <= CNT_W'(WAIT_STATES);  // Reload for the new data phase
    end
    else if (wait_cnt != '0)
      wait_cnt <= wait_cnt - CNT_W'(1);
  end

  // Payload, taken with every accepted address phase
  always_ff @(posedge HCLK)
  begin
    if (HREADY)
    begin
      dp_write <= HWRITE;
      dp_index <= HADDR[IDX_W+1:2];     // Byte address to word, wraps at depth
    end
  end

  // ------------------------------
  // Data phase
  // ------------------------------

  // Idle slave always reports ready
  assign HREADYOUT = !dp_valid || (wait_cnt == '0);
  assign HRESP     = OKAY;

  // Write lands on the completing edge
  always_ff @(posedge HCLK)
  begin
    if (dp_valid && dp_write && HREADYOUT)
      mem[dp_index] <= HWDATA;
  end

  // Read word shown once waits are done, zero otherwise
  assign HRDATA = (dp_valid && !dp_write && HREADYOUT) ? mem[dp_index] : '0;

  // Every stretch of wait states ends after exactly WAIT_STATES cycles
  a_wait_bound: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $fell(HREADYOUT) |-> ##WAIT_STATES HREADYOUT);

endmodule

// File: logic/ahb_default_slave.sv
// Default slave answering active transfers to unmapped space with a two-cycle ERROR
`timescale 1ns/1ns

module ahb_default_slave (
  input  logic             HCLK,
  input  logic             HRESETn,
  input  logic             HSEL,
  input  ahb_pkg::htrans_e HTRANS,
  input  logic             HREADY,
  output logic             HREADYOUT,
  output ahb_pkg::hresp_e  HRESP
);
  import ahb_pkg::*;

  typedef enum logic [1:0] {
    DFT_IDLE = 2'b00,  // OKAY with zero wait
    DFT_ERR1 = 2'b01,  // ERROR with ready low
    DFT_ERR2 = 2'b10   // ERROR with ready high
  } dft_state_e;

  dft_state_e state;
  dft_state_e next_state;
  logic       xfer_req;  // Active transfer accepted this cycle

  assign xfer_req = HSEL && HREADY && (HTRANS == NONSEQ || HTRANS == SEQ);

  always_comb
  begin
    case (state)
      DFT_ERR1: next_state = DFT_ERR2;
      default:  next_state = xfer_req ? DFT_ERR1 : DFT_IDLE;  // ERR2 may accept again
    endcase
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      state <= DFT_IDLE;
    else
      state <= next_state;
  end

  // Two-cycle ERROR per AHB-Lite
  assign HREADYOUT = (state != DFT_ERR1);
  assign HRESP     = (state == DFT_IDLE) ? OKAY : ERROR;

  // Ready-low ERROR cycle always leads into a ready-high ERROR cycle
  a_err_two_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !HREADYOUT |-> (HRESP == ERROR) ##1 (HREADYOUT && HRESP == ERROR));

endmodule

// File: logic/bus_map_pkg.sv
// Memory map of the slice with data-port codes and region upper bounds

package bus_map_pkg;

  // Decoder looks at HADDR[31:10] only
  localparam int DECODE_LSB = 10;

  // Port codes follow the classic matrix decode
  typedef enum logic [2:0] {
    PORT_MI0     = 3'b000,  // Region 0 SRAM
    PORT_MI1     = 3'b001,  // Region 1 SRAM
    PORT_MI2     = 3'b010,  // Region 2 SRAM
    PORT_DEFAULT = 3'b100   // Unmapped space
  } port_sel_e;

  // ------------------------------
  // Region upper bounds, in 1 KB units
  // ------------------------------
  // Region 0 starts at zero so only the tops are needed
  localparam logic [21:0] REGION0_LAST = 22'h07_ffff;  // 0x1FFF_FFFF
  localparam logic [21:0] REGION1_LAST = 22'h0f_ffff;  // 0x3FFF_FFFF
  localparam logic [21:0] REGION2_LAST = 22'h17_ffff;  // 0x5FFF_FFFF

endpackage

// File: logic/ahb_pkg.sv
// AHB-Lite protocol types and bus widths shared across the interconnect slice

package ahb_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------
  localparam int AHB_ADDR_W = 32;  // Byte address
  localparam int AHB_DATA_W = 32;  // Word data, no sub-word lanes

  // ------------------------------
  // Transfer and response codes
  // ------------------------------

  // HTRANS encoding per AHB-Lite
  typedef enum logic [1:0] {
    IDLE   = 2'b00,  // No transfer
    BUSY   = 2'b01,  // Master stalling mid-burst
    NONSEQ = 2'b10,  // Single or first beat
    SEQ    = 2'b11   // Follow-on beat
  } htrans_e;

  // Single-bit HRESP of AHB-Lite
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

endpackage
